//--- src/eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

  localparam int MAX_FRAME_LEN   = 32;  // largest frame in bytes
  localparam int BYTE_FIFO_DEPTH = 128;
  localparam int DESC_FIFO_DEPTH = 4;
  localparam int IFG_TICKS       = 12;  // idle cycles after each frame
  localparam int N_SRC           = 2;
  localparam int SRC_ARP         = 0;
  localparam int SRC_IPV4        = 1;

  // wide enough to hold MAX_FRAME_LEN itself
  localparam int LEN_W = $clog2(MAX_FRAME_LEN + 1);

  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;

  typedef struct packed {
    mac_addr_t  dst;
    mac_addr_t  src;
    ethertype_t ethertype;
  } mac_hdr_t;

  typedef logic [LEN_W-1:0] frame_len_t;

  // one entry per accepted frame, queued next to the frame bytes
  typedef struct packed {
    mac_hdr_t   hdr;
    frame_len_t len;
  } frame_desc_t;

endpackage

`default_nettype wire

//--- src/sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 16
) (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       push,
  input  wire T                           din,
  input  wire logic                       pop,
  output T                                dout,
  output logic                            empty,
  output logic [$clog2(DEPTH + 1) - 1:0]  free
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // a push into a full buffer or a pop from an empty one is ignored
  assign do_push = push && (count != CW'(DEPTH));
  assign do_pop  = pop && (count != '0);

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(do_push) - CW'(do_pop);
    end
  end

  assign dout  = mem[rd_ptr];  // head entry shows without a pop
  assign empty = (count == '0);
  assign free  = CW'(DEPTH) - count;

endmodule

`default_nettype wire

//--- src/src_buffer.sv
`default_nettype none

module src_buffer (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   v,
  input  wire logic [7:0]             d,
  input  wire eth_tx_pkg::mac_hdr_t   hdr,
  output logic                        drop,
  output logic                        desc_avail,
  output eth_tx_pkg::frame_desc_t     desc_out,
  input  wire logic                   desc_pop,
  input  wire logic                   byte_pop,
  output logic [7:0]                  byte_out
);

  import eth_tx_pkg::*;

  logic [$clog2(BYTE_FIFO_DEPTH + 1) - 1:0] byte_free;
  logic [$clog2(DESC_FIFO_DEPTH + 1) - 1:0] desc_free;

  logic        v_q;
  logic        accepting;  // the frame in progress was admitted
  logic        start;
  logic        admit;
  logic        byte_push;
  logic        desc_push;
  logic        desc_empty;
  frame_len_t  len_q;
  mac_hdr_t    hdr_q;
  frame_desc_t desc_in;

  assign start = v && !v_q;

  // room for a worst-case frame must exist before its first byte lands
  assign admit = (byte_free >= MAX_FRAME_LEN) && (desc_free != '0);

  assign byte_push = v && (start ? admit : accepting);
  assign desc_push = v_q && !v && accepting;  // the cycle after the last byte

  always_ff @(posedge clk) begin
    if (reset) begin
      v_q       <= 1'b0;
      accepting <= 1'b0;
      drop      <= 1'b0;
    end else begin
      v_q  <= v;
      drop <= start && !admit;
      if (start) accepting <= admit;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      hdr_q <= hdr;
      len_q <= frame_len_t'(1);
    end else if (v) begin
      len_q <= len_q + 1'b1;
    end
  end

  assign desc_in.hdr = hdr_q;
  assign desc_in.len = len_q;

  sync_fifo #(
    .T     (logic [7:0]),
    .DEPTH (BYTE_FIFO_DEPTH)
  ) byte_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (byte_push),
    .din   (d),
    .pop   (byte_pop),
    .dout  (byte_out),
    .empty (),
    .free  (byte_free)
  );

  sync_fifo #(
    .T     (frame_desc_t),
    .DEPTH (DESC_FIFO_DEPTH)
  ) desc_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (desc_push),
    .din   (desc_in),
    .pop   (desc_pop),
    .dout  (desc_out),
    .empty (desc_empty),
    .free  (desc_free)
  );

  assign desc_avail = !desc_empty;

endmodule

`default_nettype wire

//--- src/tx_byte_counter.sv
`default_nettype none

module tx_byte_counter (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  load,
  input  wire eth_tx_pkg::frame_len_t load_value,
  output logic                       done
);

  import eth_tx_pkg::*;

  frame_len_t count;

  // counts down every cycle and parks at zero
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // high on the last cycle of a loaded run, so a load of n spans n cycles
  assign done = (count == frame_len_t'(1));

endmodule

`default_nettype wire

//--- src/tx_arbiter_fsm.sv
`default_nettype none

module tx_arbiter_fsm (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   arp_desc_avail,
  input  wire logic                   ipv4_desc_avail,
  input  wire eth_tx_pkg::frame_len_t arp_desc_len,
  input  wire eth_tx_pkg::frame_len_t ipv4_desc_len,
  input  wire logic                   tx_rdy,
  output logic                        tx_avl,
  output logic                        cnt_load,
  output eth_tx_pkg::frame_len_t      cnt_value,
  input  wire logic                   cnt_done,
  output logic                        sel,
  output logic                        arp_desc_pop,
  output logic                        ipv4_desc_pop,
  output logic                        arp_byte_pop,
  output logic                        ipv4_byte_pop,
  output logic                        hdr_load,
  output logic                        byte_valid
);

  import eth_tx_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    OFFER,
    START,
    SEND,
    GAP
  } state_t;

  state_t state;
  logic   last_sel;  // source served most recently
  logic   pick;

  // on a tie the source that was not served last goes next
  always_comb begin
    if (arp_desc_avail && ipv4_desc_avail) begin
      pick = (last_sel == 1'(SRC_ARP)) ? 1'(SRC_IPV4) : 1'(SRC_ARP);
    end else if (ipv4_desc_avail) begin
      pick = 1'(SRC_IPV4);
    end else begin
      pick = 1'(SRC_ARP);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      sel      <= 1'(SRC_ARP);
      last_sel <= 1'(SRC_ARP);
    end else begin
      case (state)
        IDLE: begin
          if (arp_desc_avail || ipv4_desc_avail) begin
            sel   <= pick;
            state <= OFFER;
          end
        end
        OFFER: if (tx_rdy) state <= START;  // rdy only counts while offering
        START: begin
          last_sel <= sel;
          state    <= SEND;
        end
        SEND: if (cnt_done) state <= GAP;
        GAP: if (cnt_done) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign tx_avl = (state == OFFER);

  // frame length goes in on START, the gap length on the last byte
  assign cnt_load  = (state == START) || ((state == SEND) && cnt_done);
  assign cnt_value = (state == START) ?
                     ((sel == 1'(SRC_IPV4)) ? ipv4_desc_len : arp_desc_len) :
                     frame_len_t'(IFG_TICKS);

  assign hdr_load   = (state == START);
  assign byte_valid = (state == SEND);

  assign arp_desc_pop  = (state == START) && (sel == 1'(SRC_ARP));
  assign ipv4_desc_pop = (state == START) && (sel == 1'(SRC_IPV4));
  assign arp_byte_pop  = (state == SEND) && (sel == 1'(SRC_ARP));
  assign ipv4_byte_pop = (state == SEND) && (sel == 1'(SRC_IPV4));

endmodule

`default_nettype wire

//--- src/tx_output_stage.sv
`default_nettype none

module tx_output_stage (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    sel,
  input  wire logic                    hdr_load,
  input  wire logic                    byte_valid,
  input  wire eth_tx_pkg::frame_desc_t arp_desc,
  input  wire eth_tx_pkg::frame_desc_t ipv4_desc,
  input  wire logic [7:0]              arp_byte,
  input  wire logic [7:0]              ipv4_byte,
  output logic                         tx_v,
  output logic [7:0]                   tx_d,
  output eth_tx_pkg::mac_hdr_t         tx_hdr
);

  import eth_tx_pkg::*;

  logic [7:0] byte_q;
  logic       valid_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      tx_v    <= 1'b0;
    end else begin
      valid_q <= byte_valid;
      tx_v    <= valid_q;  // two stages from pop to the MAC
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_load) begin
      tx_hdr <= (sel == 1'(SRC_IPV4)) ? ipv4_desc.hdr : arp_desc.hdr;
    end
    if (byte_valid) begin
      byte_q <= (sel == 1'(SRC_IPV4)) ? ipv4_byte : arp_byte;  // head byte as it pops
    end
    tx_d <= byte_q;
  end

endmodule

`default_nettype wire

//--- src/eth_tx_mux.sv
`default_nettype none

module eth_tx_mux (
  input  wire logic                 clk,
  input  wire logic                 reset,

  input  wire logic                 arp_v,
  input  wire logic [7:0]           arp_d,
  input  wire eth_tx_pkg::mac_hdr_t arp_hdr,
  output logic                      arp_drop,

  input  wire logic                 ipv4_v,
  input  wire logic [7:0]           ipv4_d,
  input  wire eth_tx_pkg::mac_hdr_t ipv4_hdr,
  output logic                      ipv4_drop,

  output logic                      tx_avl,
  input  wire logic                 tx_rdy,
  output logic                      tx_v,
  output logic [7:0]                tx_d,
  output eth_tx_pkg::mac_hdr_t      tx_hdr
);

  import eth_tx_pkg::*;

  frame_desc_t arp_desc;
  frame_desc_t ipv4_desc;
  frame_len_t  cnt_value;
  logic [7:0]  arp_byte;
  logic [7:0]  ipv4_byte;
  logic        arp_desc_avail;
  logic        ipv4_desc_avail;
  logic        arp_desc_pop;
  logic        ipv4_desc_pop;
  logic        arp_byte_pop;
  logic        ipv4_byte_pop;
  logic        cnt_load;
  logic        cnt_done;
  logic        sel;
  logic        hdr_load;
  logic        byte_valid;

  src_buffer arp_buf (
    .clk        (clk),
    .reset      (reset),
    .v          (arp_v),
    .d          (arp_d),
    .hdr        (arp_hdr),
    .drop       (arp_drop),
    .desc_avail (arp_desc_avail),
    .desc_out   (arp_desc),
    .desc_pop   (arp_desc_pop),
    .byte_pop   (arp_byte_pop),
    .byte_out   (arp_byte)
  );

  src_buffer ipv4_buf (
    .clk        (clk),
    .reset      (reset),
    .v          (ipv4_v),
    .d          (ipv4_d),
    .hdr        (ipv4_hdr),
    .drop       (ipv4_drop),
    .desc_avail (ipv4_desc_avail),
    .desc_out   (ipv4_desc),
    .desc_pop   (ipv4_desc_pop),
    .byte_pop   (ipv4_byte_pop),
    .byte_out   (ipv4_byte)
  );

  tx_arbiter_fsm arbiter (
    .clk             (clk),
    .reset           (reset),
    .arp_desc_avail  (arp_desc_avail),
    .ipv4_desc_avail (ipv4_desc_avail),
    .arp_desc_len    (arp_desc.len),
    .ipv4_desc_len   (ipv4_desc.len),
    .tx_rdy          (tx_rdy),
    .tx_avl          (tx_avl),
    .cnt_load        (cnt_load),
    .cnt_value       (cnt_value),
    .cnt_done        (cnt_done),
    .sel             (sel),
    .arp_desc_pop    (arp_desc_pop),
    .ipv4_desc_pop   (ipv4_desc_pop),
    .arp_byte_pop    (arp_byte_pop),
    .ipv4_byte_pop   (ipv4_byte_pop),
    .hdr_load        (hdr_load),
    .byte_valid      (byte_valid)
  );

  tx_byte_counter byte_counter (
    .clk        (clk),
    .reset      (reset),
    .load       (cnt_load),
    .load_value (cnt_value),
    .done       (cnt_done)
  );

  tx_output_stage output_stage (
    .clk        (clk),
    .reset      (reset),
    .sel        (sel),
    .hdr_load   (hdr_load),
    .byte_valid (byte_valid),
    .arp_desc   (arp_desc),
    .ipv4_desc  (ipv4_desc),
    .arp_byte   (arp_byte),
    .ipv4_byte  (ipv4_byte),
    .tx_v       (tx_v),
    .tx_d       (tx_d),
    .tx_hdr     (tx_hdr)
  );

endmodule

`default_nettype wire

//--- dv/eth_tx_mux_tb.sv
`default_nettype none

module eth_tx_mux_tb;

  import eth_tx_pkg::*;

  localparam int DRAIN_TIMEOUT = 5000;  // cycles one test gets to empty out

  typedef struct packed {
    mac_hdr_t    hdr;
    logic [31:0] len;
    logic [7:0]  first;
    logic [31:0] ready;  // first cycle the FSM can see its descriptor
  } frame_t;

  logic       clk;
  logic       reset;
  logic       arp_v;
  logic [7:0] arp_d;
  mac_hdr_t   arp_hdr;
  logic       arp_drop;
  logic       ipv4_v;
  logic [7:0] ipv4_d;
  mac_hdr_t   ipv4_hdr;
  logic       ipv4_drop;
  logic       tx_avl;
  logic       tx_rdy;
  logic       tx_v;
  logic [7:0] tx_d;
  mac_hdr_t   tx_hdr;

  frame_t fq[N_SRC][$];  // accepted frames that no tx_rdy has claimed yet
  frame_t cur;
  int     used[N_SRC];   // bytes held per source until the frame leaves tx_v
  int     cur_src;
  int     cyc;
  int     errors;
  int     frames;
  int     drops;
  int     offered;
  int     last_src;
  int     rdy_k;
  int     prev_k;
  int     prev_len;
  int     idx;
  logic   rdy_en;
  logic   busy;
  logic   avl_q;
  logic   v_q;

  eth_tx_mux DUT (
    .clk       (clk),
    .reset     (reset),
    .arp_v     (arp_v),
    .arp_d     (arp_d),
    .arp_hdr   (arp_hdr),
    .arp_drop  (arp_drop),
    .ipv4_v    (ipv4_v),
    .ipv4_d    (ipv4_d),
    .ipv4_hdr  (ipv4_hdr),
    .ipv4_drop (ipv4_drop),
    .tx_avl    (tx_avl),
    .tx_rdy    (tx_rdy),
    .tx_v      (tx_v),
    .tx_d      (tx_d),
    .tx_hdr    (tx_hdr)
  );

  always #5 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic drive_src(int src, logic v, logic [7:0] d, mac_hdr_t hdr);
    if (src == SRC_ARP) begin
      arp_v   = v;
      arp_d   = d;
      arp_hdr = hdr;
    end else begin
      ipv4_v   = v;
      ipv4_d   = d;
      ipv4_hdr = hdr;
    end
  endtask

  task automatic send_frame(int src, mac_hdr_t hdr, int len, logic [7:0] first);
    logic   admit;
    logic   drop_now;
    frame_t f;
    // room for a worst-case frame and a free descriptor slot
    admit = (BYTE_FIFO_DEPTH - used[src] >= MAX_FRAME_LEN) &&
            (fq[src].size() < DESC_FIFO_DEPTH);
    for (int i = 0; i <= len; i++) begin
      @(posedge clk);
      #1;
      drive_src(src, i < len, 8'(int'(first) + i), hdr);
      if (i == 1) begin
        @(negedge clk);  // drop answers the first byte one cycle later
        drop_now = (src == SRC_ARP) ? arp_drop : ipv4_drop;
        if (drop_now != !admit) begin
          $display("** Error: %s expected 0x%0h got 0x%0h",
                   (src == SRC_ARP) ? "arp_drop" : "ipv4_drop", !admit, drop_now);
          errors++;
        end
      end
    end
    f.hdr   = hdr;
    f.len   = len;
    f.first = first;
    f.ready = cyc + 1;
    if (admit) begin
      fq[src].push_back(f);
      used[src] += len;
    end else begin
      drops++;
    end
  endtask

  // the source that was not served last wins a tie
  function automatic int pick_source(int at_cyc);
    logic a;
    logic b;
    a = (fq[SRC_ARP].size() > 0) && (int'(fq[SRC_ARP][0].ready) <= at_cyc);
    b = (fq[SRC_IPV4].size() > 0) && (int'(fq[SRC_IPV4][0].ready) <= at_cyc);
    if (a && b) return (last_src == SRC_ARP) ? SRC_IPV4 : SRC_ARP;
    if (b) return SRC_IPV4;
    return SRC_ARP;
  endfunction

  task automatic grant_frame();
    int delay;
    delay = int'($urandom % 8);
    repeat (delay) @(posedge clk);
    @(posedge clk);
    #1;
    tx_rdy = 1'b1;
    rdy_k  = cyc + 1;  // edge that samples tx_rdy
    if (fq[offered].size() == 0) begin
      $display("tx_avl was offered but the model holds no frame for that source");
      errors++;
    end else begin
      cur      = fq[offered].pop_front();
      cur_src  = offered;
      last_src = offered;
      busy     = 1'b1;
      prev_k   = rdy_k;
      prev_len = int'(cur.len);
    end
    @(posedge clk);
    #1;
    tx_rdy = 1'b0;
  endtask

  initial begin
    void'($urandom(40879));
    forever begin
      @(negedge clk);
      if (rdy_en && tx_avl && !reset) grant_frame();
    end
  end

  task automatic check_byte();
    logic [7:0] want;
    if (!v_q) begin
      idx = 0;
      if (!busy) begin
        $display("tx_v rose with no frame granted");
        errors++;
      end
      if (cyc != rdy_k + 3) begin
        $display("tx_v started %0d cycles after tx_rdy instead of 3", cyc - rdy_k);
        errors++;
      end
      if (tx_hdr != cur.hdr) begin
        $display("** Error: tx_hdr expected 0x%h got 0x%h", cur.hdr, tx_hdr);
        errors++;
      end
    end
    want = 8'(int'(cur.first) + idx);
    if (idx >= int'(cur.len)) begin
      $display("tx_v stayed high past the end of the frame");
      errors++;
    end else if (tx_d != want) begin
      $display("** Error: tx_d expected 0x%h got 0x%h", want, tx_d);
      errors++;
    end
    idx++;
  endtask

  task automatic end_frame();
    if (idx != int'(cur.len)) begin
      $display("** Error: frame length expected 0x%0h got 0x%0h", cur.len, idx);
      errors++;
    end
    used[cur_src] -= int'(cur.len);
    busy = 1'b0;
    frames++;
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      if (tx_avl && !avl_q) begin
        // last pop is len+1 edges after tx_rdy, then the gap runs
        if (prev_k >= 0 && cyc < prev_k + prev_len + 1 + IFG_TICKS) begin
          $display("tx_avl rose %0d cycles after tx_rdy, inside the gap", cyc - prev_k);
          errors++;
        end
        offered = pick_source(cyc - 1);
      end
      if (tx_v) check_byte();
      else if (v_q) end_frame();
    end
    avl_q = tx_avl;
    v_q   = tx_v;
  end

  task automatic close_test(string name, int err0, int frm0, int drp0);
    int waited;
    rdy_en = 1'b1;
    waited = 0;
    while ((fq[SRC_ARP].size() + fq[SRC_IPV4].size() > 0 || busy) &&
           waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (waited >= DRAIN_TIMEOUT) begin
      $display("%s timed out waiting for its frames to come out", name);
      errors++;
    end
    $display("test %s: %0d frames, %0d drops, %0d errors",
             name, frames - frm0, drops - drp0, errors - err0);
  endtask

  initial begin
    int          fd;
    int          n;
    int          mode;
    int          src;
    int          len;
    int          n_tests;
    int          err0;
    int          frm0;
    int          drp0;
    string       line;
    string       name;
    logic [47:0] dst;
    logic [47:0] sa;
    logic [15:0] et;
    logic [7:0]  first;
    clk      = 1'b0;
    reset    = 1'b1;
    tx_rdy   = 1'b0;
    drive_src(SRC_ARP, 1'b0, 8'h00, '0);
    drive_src(SRC_IPV4, 1'b0, 8'h00, '0);
    errors   = 0;
    frames   = 0;
    drops    = 0;
    n_tests  = 0;
    used[0]  = 0;
    used[1]  = 0;
    rdy_en   = 1'b0;
    busy     = 1'b0;
    avl_q    = 1'b0;
    v_q      = 1'b0;
    offered  = SRC_ARP;
    last_src = SRC_ARP;
    prev_k   = -1;
    name     = "";
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    if (tx_avl || tx_v || arp_drop || ipv4_drop) begin
      $display("outputs were not idle after reset");
      errors++;
    end
    fd = $fopen("dv/eth_tx_mux_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/eth_tx_mux_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line[0] == "T") begin
          if (name != "") close_test(name, err0, frm0, drp0);
          n = $sscanf(line, "T %s %d", name, mode);
          rdy_en = (mode != 0);  // held tests release tx_rdy when they close
          n_tests++;
          err0 = errors;
          frm0 = frames;
          drp0 = drops;
        end else if (n > 0 && line[0] == "F") begin
          n = $sscanf(line, "F %d %h %h %h %d %h", src, dst, sa, et, len, first);
          if (n != 6) begin
            $display("malformed frame line in the vector file");
            errors++;
          end else begin
            send_frame(src, mac_hdr_t'({dst, sa, et}), len, first);
          end
        end
      end
      $fclose(fd);
      if (name != "") close_test(name, err0, frm0, drp0);
    end
    $display("%0d tests, %0d frames, %0d drops, %0d errors", n_tests, frames, drops, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
src/eth_tx_pkg.sv
src/sync_fifo.sv
src/src_buffer.sv
src/tx_byte_counter.sv
src/tx_arbiter_fsm.sv
src/tx_output_stage.sv
src/eth_tx_mux.sv
dv/eth_tx_mux_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench and RTL with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module eth_tx_mux_tb \
  -f sim.f -o eth_tx_mux_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/eth_tx_mux_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$log"; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation passed"
exit 0

//--- dv/eth_tx_mux_vectors.txt
# T <test name> <tx_rdy: 0 held until the test ends, 1 enabled>
# F <src: 0 arp, 1 ipv4> <dst mac> <src mac> <ethertype> <length, decimal> <first byte>
T single_arp 1
F 0 ffffffffffff 02000000000a 0806 28 a0

T ipv4_order 1
F 1 020000000001 02000000000b 0800 12 10
F 1 020000000002 02000000000b 0800 20 40
F 1 020000000003 02000000000b 0800 16 80

T alternate 0
F 1 020000000004 02000000000b 0800 10 00
F 0 020000000005 02000000000a 0806 28 20
F 1 020000000006 02000000000b 0800 20 30
F 0 020000000007 02000000000a 0806 28 50
F 1 020000000008 02000000000b 0800 30 60
F 0 020000000009 02000000000a 0806 28 90

T gap_back_to_back 1
F 0 02000000000c 02000000000a 0806 8 11
F 0 02000000000d 02000000000a 0806 9 22
F 1 02000000000e 02000000000b 0800 7 33

T overflow 0
F 0 020000000010 02000000000a 0806 24 01
F 0 020000000011 02000000000a 0806 24 21
F 0 020000000012 02000000000a 0806 24 41
F 0 020000000013 02000000000a 0806 24 61
F 0 020000000014 02000000000a 0806 24 81

T edge_lengths 1
F 0 020000000020 02000000000a 0806 1 c0
F 1 020000000021 02000000000b 0800 32 e0
F 0 020000000022 02000000000a 0806 32 f0
F 1 020000000023 02000000000b 0800 1 01
